// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_dcache_system -f vlog.f
	out=$$(./obj_dir/Vtb_dcache_system); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

// ==== hw/cache_pkg.sv ====
//********************
// data cache geometry and request types
// the CPU side builds cpu_req_t, the tag arrays hold tag_entry_t
//********************

package cache_pkg;

    // 20-bit tag, 8-bit index, 4-bit byte offset
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = 20;
    localparam int OFFSET_W = 4;

    localparam int NUM_SETS = 256;
    localparam int NUM_WAYS = 2;

    // one CPU access
    typedef struct packed {
        // 1 = store
        logic                op;
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        logic [3:0]          wstrb;
        logic [31:0]         wdata;
    } cpu_req_t;

    // per-way tag entry
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tag_entry_t;

endpackage

// ==== hw/data_bank.sv ====
//********************
// one 32-bit word position of one way
// synchronous read, write lands at the clock edge
//********************

`timescale 1ns/1ps

module data_bank (
    input  logic                          clk,
    input  logic                          wen,
    input  logic [cache_pkg::INDEX_W-1:0] addr,
    input  logic [31:0]                   wdata,
    output logic [31:0]                   rdata
);
    import cache_pkg::*;

    logic [31:0] mem [NUM_SETS];

    // old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== hw/dcache.sv ====
//********************
// blocking two-way write-back data cache
// one request at a time, hits answer two cycles after acceptance,
// misses write back a dirty victim and refill over the line bus
//********************

`timescale 1ns/1ps

module dcache (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  cache_pkg::cpu_req_t  req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output logic [31:0]          rdata,
    output logic                 rd_req,
    output logic [31:0]          rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  mem_bus_pkg::line_t   ret_data,
    output logic                 wr_req,
    output mem_bus_pkg::mem_wr_t wr_line,
    input  logic                 wr_rdy
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } state_t;

    state_t state;
    state_t state_next;

    cpu_req_t           req_buf;
    logic [INDEX_W-1:0] ram_index;
    logic [1:0]         word_sel;

    tag_entry_t                                     tag_rd [NUM_WAYS];
    tag_entry_t                                     tag_wr;
    logic [NUM_WAYS-1:0]                            tag_wen;
    logic [NUM_WAYS-1:0][WORDS_PER_LINE-1:0][31:0] bank_rd;
    logic [WORDS_PER_LINE-1:0][31:0]                bank_wr;
    logic [NUM_WAYS-1:0][WORDS_PER_LINE-1:0]        bank_wen;

    logic [NUM_WAYS-1:0] hit_vec;
    logic                hit;
    logic                hit_way;
    logic                repl_way;
    logic                victim_dirty;
    line_t               hit_line;
    line_t               victim_line;
    line_t               refill_line;
    logic [31:0]         hit_word;
    logic [31:0]         store_word;

    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty;
    // most recently used way per set
    logic [NUM_SETS-1:0]               mru;

    // arrays see the incoming index in IDLE so LOOKUP has data
    assign ram_index = (state == IDLE) ? req.index : req_buf.index;
    assign word_sel  = req_buf.offset[OFFSET_W-1:2];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        tag_ram u_tag (
            .clk   (clk),
            .reset (reset),
            .wen   (tag_wen[w]),
            .addr  (ram_index),
            .wdata (tag_wr),
            .rdata (tag_rd[w])
        );
        for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
            data_bank u_bank (
                .clk   (clk),
                .wen   (bank_wen[w][b]),
                .addr  (ram_index),
                .wdata (bank_wr[b]),
                .rdata (bank_rd[w][b])
            );
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = tag_rd[w].valid && (tag_rd[w].tag == req_buf.tag);
        end
    end

    assign hit      = |hit_vec;
    assign hit_way  = hit_vec[1];
    assign hit_line = line_t'(bank_rd[hit_way]);
    assign hit_word = hit_line.words[word_sel];

    // invalid way first, else the one not recently used
    always_comb begin
        if (!tag_rd[0].valid) begin
            repl_way = 1'b0;
        end else if (!tag_rd[1].valid) begin
            repl_way = 1'b1;
        end else begin
            repl_way = ~mru[req_buf.index];
        end
    end

    assign victim_dirty = dirty[repl_way][req_buf.index];
    assign victim_line  = line_t'(bank_rd[repl_way]);

    // strobed store into the hit word
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            store_word[i*8 +: 8] = req_buf.wstrb[i] ? req_buf.wdata[i*8 +: 8]
                                                    : hit_word[i*8 +: 8];
        end
    end

    // pending store bytes over the fetched line
    always_comb begin
        refill_line = ret_data;
        if (req_buf.op) begin
            for (int i = 0; i < 4; i++) begin
                if (req_buf.wstrb[i]) begin
                    refill_line.bytes[word_sel*4 + i] = req_buf.wdata[i*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        bank_wen = '0;
        tag_wen  = '0;
        if (state == LOOKUP && hit && req_buf.op) begin
            bank_wen[hit_way][word_sel] = 1'b1;
        end
        if (state == REFILL && ret_valid) begin
            bank_wen[repl_way] = '1;
            tag_wen[repl_way]  = 1'b1;
        end
    end

    always_comb begin
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
            bank_wr[b] = (state == REFILL) ? refill_line.words[b] : store_word;
        end
    end

    assign tag_wr = '{tag: req_buf.tag, valid: 1'b1};

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (valid) state_next = LOOKUP;
            LOOKUP:  state_next = hit ? IDLE : MISS;
            MISS:    if (!victim_dirty || wr_rdy) state_next = REPLACE;
            REPLACE: if (rd_rdy) state_next = REFILL;
            REFILL:  if (ret_valid) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && valid) begin
            req_buf <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dirty <= '0;
            mru   <= '0;
        end else if (state == LOOKUP && hit) begin
            mru[req_buf.index] <= hit_way;
            if (req_buf.op) begin
                dirty[hit_way][req_buf.index] <= 1'b1;
            end
        end else if (state == REFILL && ret_valid) begin
            mru[req_buf.index]             <= repl_way;
            dirty[repl_way][req_buf.index] <= req_buf.op;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= (state == LOOKUP && hit) || (state == REFILL && ret_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            rdata <= hit_word;
        end else if (state == REFILL && ret_valid) begin
            rdata <= refill_line.words[word_sel];
        end
    end

    assign addr_ok      = (state == IDLE);
    assign rd_req       = (state == REPLACE) && rd_rdy;
    assign rd_addr      = {req_buf.tag, req_buf.index, {OFFSET_W{1'b0}}};
    assign wr_req       = (state == MISS) && victim_dirty && wr_rdy;
    assign wr_line.addr = {tag_rd[repl_way].tag, req_buf.index, {OFFSET_W{1'b0}}};
    assign wr_line.data = victim_line;

endmodule

// ==== hw/dcache_system.sv ====
//********************
// data cache joined to its backing memory
// the CPU side is the only external interface
//********************

`timescale 1ns/1ps

module dcache_system (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  cache_pkg::cpu_req_t req,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [31:0]         rdata
);
    import mem_bus_pkg::*;

    // line bus
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    line_t       ret_data;
    logic        wr_req;
    mem_wr_t     wr_line;
    logic        wr_rdy;

    dcache u_dcache (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_line   (wr_line),
        .wr_rdy    (wr_rdy)
    );

    line_memory u_mem (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_line   (wr_line),
        .wr_rdy    (wr_rdy)
    );

endmodule

// ==== hw/line_memory.sv ====
//********************
// backing memory on the line bus
// reads return after MEM_LATENCY cycles, writes leave it busy for WR_BUSY
//********************

`timescale 1ns/1ps

module line_memory (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rd_req,
    input  logic [31:0]          rd_addr,
    output logic                 rd_rdy,
    output logic                 ret_valid,
    output mem_bus_pkg::line_t   ret_data,
    input  logic                 wr_req,
    input  mem_bus_pkg::mem_wr_t wr_line,
    output logic                 wr_rdy
);
    import mem_bus_pkg::*;

    line_t                              mem [MEM_LINES];
    logic [MEM_IDX_W-1:0]               rd_idx;
    logic [$clog2(MEM_LATENCY+1)-1:0]   rd_cnt;
    logic [$clog2(WR_BUSY+1)-1:0]       wr_cnt;

    initial begin
        for (int i = 0; i < MEM_LINES; i++) begin
            mem[i] = '0;
        end
    end

    // read latency counter
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_cnt    <= '0;
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= (rd_cnt == 1);
            if (rd_req) begin
                rd_cnt <= $bits(rd_cnt)'(MEM_LATENCY - 1);
            end else if (rd_cnt != 0) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_idx <= rd_addr[LINE_OFFSET_W +: MEM_IDX_W];
        end
        if (rd_cnt == 1) begin
            ret_data <= mem[rd_idx];
        end
    end

    // write busy counter
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_cnt <= '0;
        end else if (wr_req) begin
            wr_cnt <= $bits(wr_cnt)'(WR_BUSY);
        end else if (wr_cnt != 0) begin
            wr_cnt <= wr_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req) begin
            mem[wr_line.addr[LINE_OFFSET_W +: MEM_IDX_W]] <= wr_line.data;
        end
    end

    assign rd_rdy = (rd_cnt == 0) && !ret_valid;
    assign wr_rdy = (wr_cnt == 0);

endmodule

// ==== hw/mem_bus_pkg.sv ====
//********************
// line bus and backing memory definitions
// shared by the data cache and the line memory that serves it
//********************

package mem_bus_pkg;

    localparam int LINE_W         = 128;
    localparam int WORDS_PER_LINE = 4;

    // byte offset bits below the line index
    localparam int LINE_OFFSET_W  = $clog2(LINE_W / 8);

    // 1024 lines, address bits above 13 alias
    localparam int MEM_LINES      = 1024;
    localparam int MEM_IDX_W      = $clog2(MEM_LINES);

    localparam int MEM_LATENCY    = 4;
    localparam int WR_BUSY        = 3;

    // one line seen as words (load select, banks) or bytes (strobe merge)
    typedef union packed {
        logic [WORDS_PER_LINE-1:0][31:0] words;
        logic [LINE_W/8-1:0][7:0]        bytes;
    } line_t;

    // write-back payload
    typedef struct packed {
        logic [31:0] addr;
        line_t       data;
    } mem_wr_t;

endpackage

// ==== hw/tag_ram.sv ====
//********************
// tag array of one cache way
// read data follows the index by one cycle, valid bits clear on reset
//********************

`timescale 1ns/1ps

module tag_ram (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wen,
    input  logic [cache_pkg::INDEX_W-1:0] addr,
    input  cache_pkg::tag_entry_t       wdata,
    output cache_pkg::tag_entry_t       rdata
);
    import cache_pkg::*;

    logic [TAG_W-1:0]    tags [NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (wen) begin
            valid_bits[addr] <= wdata.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            tags[addr] <= wdata.tag;
        end
        rdata <= '{tag: tags[addr], valid: valid_bits[addr]};
    end

endmodule

// ==== testbench/dcache_stimulus.txt ====
# group op address wstrb wdata expected_rdata expected_hit
# op 1 is a store, hex for address, wstrb and data, rdata checked for loads only
# cold load, then reload hits
1 0 00000010 0 00000000 00000000 0
1 0 00000010 0 00000000 00000000 1
1 0 7ffff070 0 00000000 00000000 0
1 0 7ffff070 0 00000000 00000000 1
# full store, then low half store, then load
2 1 00000024 f 11223344 00000000 0
2 1 00000024 3 0000aabb 00000000 1
2 0 00000024 0 00000000 1122aabb 1
# store miss allocates the line
3 1 00000038 c 55660000 00000000 0
3 0 00000030 0 00000000 00000000 1
3 0 00000038 0 00000000 55660000 1
# three tags in one set, evicted dirty lines come back from memory
4 1 00000040 f a0a0a0a0 00000000 0
4 1 00001040 f b1b1b1b1 00000000 0
4 1 00002040 f c2c2c2c2 00000000 0
4 0 00000040 0 00000000 a0a0a0a0 0
4 0 00001040 0 00000000 b1b1b1b1 0
4 0 00002040 0 00000000 c2c2c2c2 0
# A touched again, C evicts B
5 1 00000050 f 0a0a0a0a 00000000 0
5 1 00001050 f 0b0b0b0b 00000000 0
5 0 00000050 0 00000000 0a0a0a0a 1
5 0 00002050 0 00000000 00000000 0
5 0 00000050 0 00000000 0a0a0a0a 1
5 0 00001050 0 00000000 0b0b0b0b 0
# both ways of one set keep their own data
6 1 00000064 f 12345678 00000000 0
6 1 00001064 f 9abcdef0 00000000 0
6 0 00000064 0 00000000 12345678 1
6 0 00001064 0 00000000 9abcdef0 1
6 0 00000060 0 00000000 00000000 1
6 1 00001064 1 000000ff 00000000 1
6 0 00001064 0 00000000 9abcdeff 1
6 0 00000064 0 00000000 12345678 1

// ==== testbench/tb_dcache_system.sv ====
//********************
// testbench for the data cache with its backing memory
// replays requests from a stimulus file and checks load data
// and hit or miss latency
//********************

`timescale 1ns/1ps

module tb_dcache_system;
    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam int HIT_LATENCY      = 2;
    localparam int MISS_MIN_LATENCY = 2 + 1 + MEM_LATENCY + 1;

    // one line of the stimulus file
    typedef struct packed {
        logic [7:0]  group;
        logic        op;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_hit;
    } stim_t;

    logic        clk;
    logic        reset;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;

    stim_t stims[$];
    int    cycle_count;
    int    cycle_limit;

    dcache_system DUT (
        .clk     (clk),
        .reset   (reset),
        .valid   (valid),
        .req     (req),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: %0d cycles passed and the request list is not done", cycle_count);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        int          grp;
        int          op;
        int          hit;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [31:0] exp;
        string       line;
        stim_t       s;
        fd = $fopen("testbench/dcache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/dcache_stimulus.txt");
            $display("Simulation FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip blank and comment lines
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %h %h %h %h %d", grp, op, addr, wstrb, wdata, exp, hit);
            if (n != 7) begin
                $display("stimulus line does not have seven columns: %s", line);
                $display("Simulation FAILED");
                $fatal(1);
            end
            s.group     = grp[7:0];
            s.op        = op[0];
            s.addr      = addr;
            s.wstrb     = wstrb;
            s.wdata     = wdata;
            s.exp_rdata = exp;
            s.exp_hit   = hit[0];
            stims.push_back(s);
        end
        $fclose(fd);
    endtask

    // issue one request and wait for data_ok
    task automatic run_request(input stim_t s, input int num);
        int    cycles;
        string name;
        name = $sformatf("behavior %0d request %0d", s.group, num);
        while (!addr_ok) begin
            @(posedge clk);
            #1;
        end
        valid      = 1'b1;
        req.op     = s.op;
        req.tag    = s.addr[31 -: TAG_W];
        req.index  = s.addr[OFFSET_W +: INDEX_W];
        req.offset = s.addr[OFFSET_W-1:0];
        req.wstrb  = s.wstrb;
        req.wdata  = s.wdata;
        // cycle of acceptance counts as 0
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            valid  = 1'b0;
            cycles = cycles + 1;
            // no new request taken while busy
            if (!data_ok) begin
                check({name, " addr_ok low while busy"}, 32'd0, 32'(addr_ok));
            end
        end while (!data_ok);

        check({name, " addr_ok back with data_ok"}, 32'd1, 32'(addr_ok));
        check({name, " hit"}, 32'(s.exp_hit), 32'(cycles == HIT_LATENCY));
        if (!s.exp_hit) begin
            check({name, " miss latency reaches minimum"}, 32'd1,
                  32'(cycles >= MISS_MIN_LATENCY));
        end
        if (!s.op) begin
            check({name, " rdata"}, s.exp_rdata, rdata);
        end
    endtask

    initial begin
        reset       = 1'b1;
        valid       = 1'b0;
        req         = '0;
        cycle_count = 0;
        cycle_limit = 100;
        load_stimulus();
        if (stims.size() == 0) begin
            $display("stimulus file holds no requests");
            $display("Simulation FAILED");
            $fatal(1);
        end
        cycle_limit = stims.size() * 30 + 100;

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        foreach (stims[i]) begin
            run_request(stims[i], i);
        end
        $display("%0d requests checked in %0d cycles", stims.size(), cycle_count);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/mem_bus_pkg.sv
hw/cache_pkg.sv
hw/tag_ram.sv
hw/data_bank.sv
hw/dcache.sv
hw/line_memory.sv
hw/dcache_system.sv
testbench/tb_dcache_system.sv
